/* logic/tlb_pkg.sv */
package tlb_pkg;

    // address and field widths
    localparam int VADDR_W     = 32;
    localparam int PADDR_W     = 32;
    localparam int VPN2_W      = 19; // vaddr[31:13], one even/odd page pair
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;
    localparam int OFFSET_W    = 12;
    localparam int CATTR_W     = 3;
    localparam int TLB_INDEX_W = 5;  // covers up to 32 entries

    typedef logic [VADDR_W-1:0]     vaddr_t;
    typedef logic [PADDR_W-1:0]     paddr_t;
    typedef logic [VPN2_W-1:0]      vpn2_t;
    typedef logic [ASID_W-1:0]      asid_t;
    typedef logic [PFN_W-1:0]       pfn_t;
    typedef logic [CATTR_W-1:0]     cattr_t;
    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;

    // cache attribute meaning cacheable, noncoherent write-back
    localparam cattr_t CATTR_CACHED = 3'd3;

    // top three vaddr bits of the unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // mapping of a single page, half of an entry
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d; // dirty, page is writable
        logic   v; // valid
    } tlb_page_t;

    // one joint TLB entry, the odd page sits above the even page
    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page1;
        tlb_page_t page0;
    } tlb_entry_t;

    // data-side translation request
    typedef struct packed {
        logic   ren;
        logic   wen;
        asid_t  asid;
        vaddr_t vaddr;
    } tlb_dreq_t;

    // registered translation result
    typedef struct packed {
        logic   valid;
        paddr_t paddr;
        logic   miss;
        logic   invalid;
        logic   modified; // store to a clean page
        logic   cache;
    } tlb_dresp_t;

endpackage

/* logic/tlb_entry_array.sv */
module tlb_entry_array #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // indexed write
    input  logic                                   w_valid,
    input  tlb_pkg::tlb_index_t                    w_index,
    input  tlb_pkg::tlb_entry_t                    w_entry,

    // indexed read
    input  tlb_pkg::tlb_index_t                    r_index,
    output tlb_pkg::tlb_entry_t                    r_entry,

    // every entry, to the matchers
    output tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0]  entries
);

    import tlb_pkg::*;

    // entry registers
    // an index beyond NUM_ENTRIES never matches, so such writes are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entries <= '0;
        end else if (w_valid) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (w_index == tlb_index_t'(i)) begin
                    entries[i] <= w_entry;
                end
            end
        end
    end

    // read mux
    always_comb begin
        r_entry = '0; // out of range reads as zero
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (r_index == tlb_index_t'(i)) begin
                r_entry = entries[i];
            end
        end
    end

endmodule

/* logic/tlb_match.sv */
module tlb_match #(
    parameter int NUM_ENTRIES = 32
) (
    input  tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0]  entries,
    input  tlb_pkg::vpn2_t                         vpn2,
    input  tlb_pkg::asid_t                         asid,
    output logic                                   hit,
    output tlb_pkg::tlb_index_t                    index
);

    import tlb_pkg::*;

    logic [NUM_ENTRIES-1:0] match_vec;

    // parallel compare, a global entry ignores the ASID
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match_vec[i] = (entries[i].vpn2 == vpn2) &&
                           (entries[i].g || (entries[i].asid == asid));
        end
    end

    // priority encoder
    // walk downward so the lowest matching index is assigned last
    always_comb begin
        hit   = 1'b0;
        index = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit   = 1'b1;
                index = tlb_index_t'(i);
            end
        end
    end

endmodule

/* logic/tlb_data_translate.sv */
module tlb_data_translate #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0]  entries,
    input  tlb_pkg::tlb_dreq_t                     req,
    output tlb_pkg::tlb_dresp_t                    resp
);

    import tlb_pkg::*;

    logic       req_present;
    logic [2:0] seg;
    logic       unmapped;
    vpn2_t      req_vpn2;

    logic       hit;
    tlb_index_t hit_index;
    tlb_entry_t hit_entry;
    tlb_page_t  page;

    tlb_dresp_t resp_d;
    tlb_dresp_t resp_q;

    assign req_present = req.ren | req.wen;
    assign seg         = req.vaddr[VADDR_W-1 -: 3];
    assign unmapped    = (seg == SEG_KSEG0) || (seg == SEG_KSEG1);
    assign req_vpn2    = req.vaddr[VADDR_W-1 -: VPN2_W];

    tlb_match #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_tlb_match (
        .entries (entries),
        .vpn2    (req_vpn2),
        .asid    (req.asid),
        .hit     (hit),
        .index   (hit_index)
    );

    // pick the matched entry
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (hit_index == tlb_index_t'(i)) begin
                hit_entry = entries[i];
            end
        end
    end

    // vaddr bit 12 picks the odd page of the pair
    assign page = req.vaddr[OFFSET_W] ? hit_entry.page1 : hit_entry.page0;

    // next response
    always_comb begin
        resp_d = '0;
        if (req_present) begin
            resp_d.valid = 1'b1;
            if (unmapped) begin
                // kseg0/kseg1 drop the segment bits
                resp_d.paddr = {3'b000, req.vaddr[VADDR_W-4:0]};
                resp_d.cache = (seg == SEG_KSEG0);
            end else if (!hit) begin
                resp_d.miss = 1'b1;
            end else begin
                resp_d.paddr    = {page.pfn, req.vaddr[OFFSET_W-1:0]};
                resp_d.invalid  = ~page.v;
                resp_d.modified = req.wen & ~page.d;
                resp_d.cache    = (page.c == CATTR_CACHED);
            end
        end
    end

    // one cycle response stage, no stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_q <= '0;
        end else begin
            resp_q <= resp_d;
        end
    end

    assign resp = resp_q;

endmodule

/* logic/tlb_top.sv */
module tlb_top #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // indexed write
    input  logic                 w_valid,
    input  tlb_pkg::tlb_index_t  w_index,
    input  tlb_pkg::tlb_entry_t  w_entry,

    // indexed read
    input  tlb_pkg::tlb_index_t  r_index,
    output tlb_pkg::tlb_entry_t  r_entry,

    // probe
    input  tlb_pkg::vpn2_t       p_vpn2,
    input  tlb_pkg::asid_t       p_asid,
    output tlb_pkg::tlb_index_t  p_index,
    output logic                 p_miss,

    // data-side translation
    input  tlb_pkg::tlb_dreq_t   d_req,
    output tlb_pkg::tlb_dresp_t  d_resp
);

    import tlb_pkg::*;

    tlb_entry_t [NUM_ENTRIES-1:0] entries;
    logic                         probe_hit;

    tlb_entry_array #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_tlb_entry_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_valid (w_valid),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // probe matcher, purely combinational
    tlb_match #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_tlb_probe (
        .entries (entries),
        .vpn2    (p_vpn2),
        .asid    (p_asid),
        .hit     (probe_hit),
        .index   (p_index)
    );

    assign p_miss = ~probe_hit;

    tlb_data_translate #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_tlb_data_translate (
        .clk     (clk),
        .rst_n   (rst_n),
        .entries (entries),
        .req     (d_req),
        .resp    (d_resp)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* tb/tlb_model.svh */
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

typedef struct packed {
    logic       miss;
    tlb_index_t index;
} probe_result_t;

// mirror of the entry table
tlb_entry_t model_entries [NUM_ENTRIES];

function automatic void model_clear();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        model_entries[i] = '0;
    end
endfunction

function automatic void model_write(input tlb_index_t idx, input tlb_entry_t e);
    if (int'(idx) < NUM_ENTRIES) begin // no entry behind that index
        model_entries[int'(idx)] = e;
    end
endfunction

function automatic tlb_entry_t model_read(input tlb_index_t idx);
    tlb_entry_t e;
    e = '0;
    if (int'(idx) < NUM_ENTRIES) begin
        e = model_entries[int'(idx)];
    end
    return e;
endfunction

// first matching entry wins
function automatic probe_result_t model_probe(input vpn2_t vpn2, input asid_t asid);
    probe_result_t r;
    r.miss  = 1'b1;
    r.index = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (r.miss && model_entries[i].vpn2 == vpn2 &&
            (model_entries[i].g || model_entries[i].asid == asid)) begin
            r.miss  = 1'b0;
            r.index = tlb_index_t'(i);
        end
    end
    return r;
endfunction

function automatic tlb_dresp_t model_translate(input tlb_dreq_t req);
    tlb_dresp_t    r;
    probe_result_t pr;
    tlb_entry_t    e;
    tlb_page_t     pg;
    logic [2:0]    seg;
    r   = '0;
    seg = req.vaddr[31:29];
    pr  = model_probe(req.vaddr[31:13], req.asid);
    e   = model_read(pr.index);
    pg  = req.vaddr[12] ? e.page1 : e.page0;
    if (req.ren || req.wen) begin
        r.valid = 1'b1;
        if (seg == SEG_KSEG0 || seg == SEG_KSEG1) begin
            r.paddr = {3'b000, req.vaddr[28:0]};
            r.cache = (seg == SEG_KSEG0);
        end else if (pr.miss) begin
            r.miss = 1'b1;
        end else begin
            r.paddr    = {pg.pfn, req.vaddr[11:0]};
            r.invalid  = !pg.v;
            r.modified = req.wen && !pg.d;
            r.cache    = (pg.c == CATTR_CACHED);
        end
    end
    return r;
endfunction

`endif

/* tb/tb_tlb.sv */
module tb_tlb;

    import tlb_pkg::*;

    localparam int NUM_ENTRIES  = 32;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 400;
    // directed phases take under three cycles per entry plus a few dozen
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 * NUM_ENTRIES + 40 + NUM_RANDOM;

    logic        clk;
    logic        rst_n;
    logic        w_valid;
    tlb_index_t  w_index;
    tlb_entry_t  w_entry;
    tlb_index_t  r_index;
    tlb_entry_t  r_entry;
    vpn2_t       p_vpn2;
    asid_t       p_asid;
    tlb_index_t  p_index;
    logic        p_miss;
    tlb_dreq_t   d_req;
    tlb_dresp_t  d_resp;

    string       test_name = "reset";
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] rng_state = 32'd58888;

    `include "tlb_model.svh"

    tb_clock #(
        .PERIOD (CLK_PERIOD)
    ) i_tb_clock (
        .clk (clk)
    );

    tlb_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_tlb_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_valid (w_valid),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .p_vpn2  (p_vpn2),
        .p_asid  (p_asid),
        .p_index (p_index),
        .p_miss  (p_miss),
        .d_req   (d_req),
        .d_resp  (d_resp)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic tlb_entry_t random_entry();
        logic [95:0] bits;
        bits = {next_random(), next_random(), next_random()};
        return bits[$bits(tlb_entry_t)-1:0];
    endfunction

    function automatic tlb_page_t make_page(input pfn_t pfn, input cattr_t c,
                                            input logic d, input logic v);
        tlb_page_t p;
        p.pfn = pfn;
        p.c   = c;
        p.d   = d;
        p.v   = v;
        return p;
    endfunction

    function automatic tlb_entry_t make_entry(input vpn2_t vpn2, input asid_t asid,
                                              input logic g, input tlb_page_t page1,
                                              input tlb_page_t page0);
        tlb_entry_t e;
        e.vpn2  = vpn2;
        e.asid  = asid;
        e.g     = g;
        e.page1 = page1;
        e.page0 = page0;
        return e;
    endfunction

    // inputs change shortly after the edge and one-shot controls drop back
    task automatic next_cycle();
        @(posedge clk);
        #1;
        w_valid = 1'b0;
        d_req   = '0;
    endtask

    task automatic write_entry(input tlb_index_t idx, input tlb_entry_t e);
        next_cycle();
        w_valid = 1'b1;
        w_index = idx;
        w_entry = e;
    endtask

    task automatic read_entry(input tlb_index_t idx);
        next_cycle();
        r_index = idx;
    endtask

    task automatic probe_entry(input vpn2_t vpn2, input asid_t asid);
        next_cycle();
        p_vpn2 = vpn2;
        p_asid = asid;
    endtask

    task automatic request_translation(input logic ren, input logic wen,
                                       input asid_t asid, input vaddr_t vaddr);
        next_cycle();
        d_req.ren   = ren;
        d_req.wen   = wen;
        d_req.asid  = asid;
        d_req.vaddr = vaddr;
    endtask

    task automatic run_random_mix();
        logic [31:0] r;
        logic [31:0] r2;
        tlb_entry_t  e;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            next_cycle();
            r  = next_random();
            r2 = next_random();
            if (r[1:0] == 2'b00) begin
                w_valid = 1'b1;
                w_index = r[6:2];
                w_entry = random_entry();
            end
            r_index   = r[11:7];
            e         = model_read(r[16:12]);
            d_req.ren = r[17];
            d_req.wen = r[18];
            if (r[19]) begin // aim at a stored entry
                d_req.vaddr = {e.vpn2, r2[12:0]};
                d_req.asid  = e.g ? r2[20:13] : e.asid;
            end else begin
                d_req.vaddr = next_random();
                d_req.asid  = r2[20:13];
            end
            if (r[20]) begin
                p_vpn2 = e.vpn2;
                p_asid = e.asid;
            end else begin
                p_vpn2 = r2[31:13];
                p_asid = r[28:21];
            end
        end
    endtask

    // read and probe are checked in their own cycle and each response one cycle later
    tlb_dresp_t exp_resp;
    string      exp_resp_test;
    logic       reset_seen = 1'b0;

    always @(posedge clk) begin
        tlb_entry_t    exp_entry;
        probe_result_t exp_probe;
        if (!rst_n) begin
            model_clear();
            exp_resp      = '0;
            exp_resp_test = "reset";
            reset_seen    = 1'b1;
        end else if (reset_seen) begin
            check_count++;
            assert (d_resp === exp_resp) else begin
                $display("FAILED %s: d_resp expected %h, got %h",
                         exp_resp_test, exp_resp, d_resp);
                error_count++;
            end
            exp_entry = model_read(r_index);
            assert (r_entry === exp_entry) else begin
                $display("FAILED %s: r_entry[%0d] expected %h, got %h",
                         test_name, r_index, exp_entry, r_entry);
                error_count++;
            end
            exp_probe = model_probe(p_vpn2, p_asid);
            assert ({p_miss, p_index} === {exp_probe.miss, exp_probe.index}) else begin
                $display("FAILED %s: probe expected miss=%0b index=%0d, got miss=%0b index=%0d",
                         test_name, exp_probe.miss, exp_probe.index, p_miss, p_index);
                error_count++;
            end
            exp_resp      = model_translate(d_req); // table before this edge's write
            exp_resp_test = test_name;
            if (w_valid) begin
                model_write(w_index, w_entry);
            end
        end
    end

    initial begin
        tlb_page_t   even_page;
        tlb_page_t   odd_page;
        logic [31:0] r;
        rst_n   = 1'b0;
        w_valid = 1'b1; // a write and a request held during reset must leave no trace
        w_index = '0;
        w_entry = '1;
        r_index = '0;
        p_vpn2  = '0;
        p_asid  = '0;
        d_req   = '0;
        d_req.ren = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        w_valid = 1'b0;
        d_req   = '0;

        test_name = "reset";
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            read_entry(tlb_index_t'(i));
        end

        test_name = "write_read";
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_entry(tlb_index_t'(i), random_entry());
            read_entry(tlb_index_t'(i));
        end

        test_name = "probe";
        even_page = make_page(20'h0cafe, 3'd3, 1'b0, 1'b1);
        odd_page  = make_page(20'hbeef1, 3'd2, 1'b1, 1'b0);
        write_entry(5'd4, make_entry(19'h12345, 8'h21, 1'b0, odd_page, even_page));
        write_entry(5'd9, make_entry(19'h0abcd, 8'h55, 1'b1, odd_page, even_page));
        write_entry(5'd11, make_entry(19'h33333, 8'h40, 1'b0, odd_page, even_page));
        write_entry(5'd6, make_entry(19'h33333, 8'h40, 1'b0, even_page, odd_page));
        probe_entry(19'h12345, 8'h21);
        probe_entry(19'h0abcd, 8'h99); // global entry matches any ASID
        probe_entry(19'h12345, 8'h22);
        probe_entry(19'h33333, 8'h40); // entries 6 and 11 both match

        test_name = "unmapped";
        r = next_random();
        request_translation(1'b1, 1'b0, 8'h21, {SEG_KSEG0, r[28:0]});
        request_translation(1'b0, 1'b1, 8'h21, {SEG_KSEG1, r[28:0]});
        request_translation(1'b1, 1'b1, 8'h00, {SEG_KSEG0, r[31:3]});
        request_translation(1'b1, 1'b0, 8'h55, {SEG_KSEG1, r[31:3]});

        test_name = "mapped";
        request_translation(1'b1, 1'b0, 8'h21, {19'h12345, 1'b0, 12'h234});
        request_translation(1'b0, 1'b1, 8'h21, {19'h12345, 1'b0, 12'h234});
        request_translation(1'b1, 1'b0, 8'h21, {19'h12345, 1'b1, 12'h678});
        request_translation(1'b0, 1'b1, 8'h21, {19'h12345, 1'b1, 12'h678});
        request_translation(1'b1, 1'b0, 8'h22, {19'h12345, 1'b0, 12'h234});
        request_translation(1'b0, 1'b1, 8'h07, {19'h33333, 1'b1, 12'hfff});
        write_entry(5'd13, make_entry(19'h05555, 8'h21, 1'b0, odd_page, even_page));
        d_req.ren   = 1'b1; // sampled with the write so it still sees the old entry
        d_req.asid  = 8'h21;
        d_req.vaddr = {19'h05555, 13'h0abc};
        request_translation(1'b1, 1'b0, 8'h21, {19'h05555, 13'h1abc});
        request_translation(1'b0, 1'b1, 8'h21, {19'h05555, 13'h0abc});

        test_name = "random";
        run_random_mix();

        next_cycle();
        repeat (2) @(posedge clk); // last response still to compare
        #1;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tb
logic/tlb_pkg.sv
logic/tlb_entry_array.sv
logic/tlb_match.sv
logic/tlb_data_translate.sv
logic/tlb_top.sv
tb/tb_clock.sv
tb/tb_tlb.sv

/* Makefile */
TOP := tb_tlb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir
